//--- rv_ctrl_params.svh
`ifndef RV_CTRL_PARAMS_SVH
`define RV_CTRL_PARAMS_SVH

// datapath widths
`define RV_XLEN 32
`define RV_HALF 16
`define RV_REG_BITS 5
// pc advance per fetched halfword
`define RV_INSTR_STEP 2

// major opcodes, instruction bits 6..2
`define RV_OP_LOAD 5'b00000
`define RV_OP_STORE 5'b01000
`define RV_OP_IMM 5'b00100
`define RV_OP_REG 5'b01100
`define RV_OP_LUI 5'b01101
`define RV_OP_AUIPC 5'b00101
`define RV_OP_JAL 5'b11011
`define RV_OP_JALR 5'b11001
`define RV_OP_BRANCH 5'b11000

// branch funct3 codes
`define RV_F3_BEQ 3'b000
`define RV_F3_BNE 3'b001
`define RV_F3_BLT 3'b100
`define RV_F3_BGE 3'b101
`define RV_F3_BLTU 3'b110
`define RV_F3_BGEU 3'b111

`endif

//--- rv_isa_pkg.sv
`include "rv_ctrl_params.svh"

package rv_isa_pkg;

  // register value or byte address
  typedef logic [`RV_XLEN-1:0] word_t;

  // one memory beat
  typedef logic [`RV_HALF-1:0] half_t;

  // x0..x31
  typedef logic [`RV_REG_BITS-1:0] reg_addr_t;

  // instruction function fields
  typedef logic [2:0] funct3_t;
  typedef logic [6:0] funct7_t;

  // full instruction, fetched as two halves
  typedef logic [31:0] instr_t;

endpackage

//--- rv_ctrl_pkg.sv
package rv_ctrl_pkg;

  // sequencer states
  typedef enum logic [2:0] {
    ST_START,
    ST_FETCH_LO,
    ST_FETCH_HI,
    ST_EXEC,
    // second beat of a word access
    ST_MEM_HI
  } seq_state_t;

  // decoded operation class, picks the execute routine
  typedef enum logic [3:0] {
    OC_ALU_REG,
    OC_ALU_IMM,
    OC_LUI,
    OC_AUIPC,
    OC_JAL,
    OC_JALR,
    OC_BRANCH,
    OC_LOAD_BH,
    OC_LOAD_W,
    OC_STORE_BH,
    OC_STORE_W,
    OC_NOP
  } op_class_t;

  // memory address source
  typedef enum logic [1:0] {AS_PC, AS_LOAD, AS_STORE} addr_sel_t;

  // register write value source
  typedef enum logic [2:0] {WB_ALU, WB_UPPER, WB_UPPER_PC, WB_LOAD, WB_LINK} wb_sel_t;

  // next pc source
  typedef enum logic [1:0] {PS_STEP, PS_JAL, PS_JALR, PS_BRANCH} pc_sel_t;

endpackage

//--- rv_sequencer.sv
`timescale 1ns/1ps

module rv_sequencer (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  rv_ctrl_pkg::op_class_t op_class_i,
  output logic                   mem_read_o,
  output logic                   mem_write_o,
  output logic                   instr_lo_we_o,
  output logic                   instr_hi_we_o,
  output rv_ctrl_pkg::addr_sel_t addr_sel_o,
  output logic                   upper_half_o,
  output logic                   load_latch_o,
  output logic                   reg_write_o,
  output rv_ctrl_pkg::wb_sel_t   wb_sel_o,
  output rv_ctrl_pkg::pc_sel_t   pc_sel_o,
  output logic                   pc_write_req_o,
  output logic                   branch_en_o,
  output logic                   alu_imm_o
);

  rv_ctrl_pkg::seq_state_t state_q;
  rv_ctrl_pkg::seq_state_t state_d;
  // word loads and stores need a second memory beat
  logic                    wide_access;

  assign wide_access = (op_class_i == rv_ctrl_pkg::OC_LOAD_W) ||
                       (op_class_i == rv_ctrl_pkg::OC_STORE_W);

  always_comb begin
    case (state_q)
      rv_ctrl_pkg::ST_FETCH_LO: state_d = rv_ctrl_pkg::ST_FETCH_HI;
      rv_ctrl_pkg::ST_FETCH_HI: state_d = rv_ctrl_pkg::ST_EXEC;
      rv_ctrl_pkg::ST_EXEC: begin
        state_d = wide_access ? rv_ctrl_pkg::ST_MEM_HI : rv_ctrl_pkg::ST_FETCH_LO;
      end
      // start and mem_hi both go back to fetch
      default: state_d = rv_ctrl_pkg::ST_FETCH_LO;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= rv_ctrl_pkg::ST_START;
    end else begin
      state_q <= state_d;
    end
  end

  // strobes from state and op class
  always_comb begin
    mem_read_o     = 1'b0;
    mem_write_o    = 1'b0;
    instr_lo_we_o  = 1'b0;
    instr_hi_we_o  = 1'b0;
    addr_sel_o     = rv_ctrl_pkg::AS_PC;
    upper_half_o   = 1'b0;
    load_latch_o   = 1'b0;
    reg_write_o    = 1'b0;
    wb_sel_o       = rv_ctrl_pkg::WB_ALU;
    pc_sel_o       = rv_ctrl_pkg::PS_STEP;
    pc_write_req_o = 1'b0;
    branch_en_o    = 1'b0;
    alu_imm_o      = 1'b0;
    case (state_q)
      rv_ctrl_pkg::ST_FETCH_LO, rv_ctrl_pkg::ST_FETCH_HI: begin
        // read at pc, step pc by one halfword
        mem_read_o     = 1'b1;
        pc_write_req_o = 1'b1;
        instr_lo_we_o  = (state_q == rv_ctrl_pkg::ST_FETCH_LO);
        instr_hi_we_o  = (state_q == rv_ctrl_pkg::ST_FETCH_HI);
      end
      rv_ctrl_pkg::ST_EXEC: begin
        case (op_class_i)
          rv_ctrl_pkg::OC_ALU_REG: reg_write_o = 1'b1;
          rv_ctrl_pkg::OC_ALU_IMM: begin
            reg_write_o = 1'b1;
            alu_imm_o   = 1'b1;
          end
          rv_ctrl_pkg::OC_LUI: begin
            reg_write_o = 1'b1;
            wb_sel_o    = rv_ctrl_pkg::WB_UPPER;
          end
          rv_ctrl_pkg::OC_AUIPC: begin
            reg_write_o = 1'b1;
            wb_sel_o    = rv_ctrl_pkg::WB_UPPER_PC;
          end
          rv_ctrl_pkg::OC_JAL, rv_ctrl_pkg::OC_JALR: begin
            // link and jump in one cycle
            reg_write_o    = 1'b1;
            wb_sel_o       = rv_ctrl_pkg::WB_LINK;
            pc_write_req_o = 1'b1;
            pc_sel_o       = (op_class_i == rv_ctrl_pkg::OC_JAL) ?
                             rv_ctrl_pkg::PS_JAL : rv_ctrl_pkg::PS_JALR;
          end
          rv_ctrl_pkg::OC_BRANCH: begin
            // pc write decided by the flags
            pc_sel_o    = rv_ctrl_pkg::PS_BRANCH;
            branch_en_o = 1'b1;
          end
          rv_ctrl_pkg::OC_LOAD_BH: begin
            mem_read_o  = 1'b1;
            addr_sel_o  = rv_ctrl_pkg::AS_LOAD;
            reg_write_o = 1'b1;
            wb_sel_o    = rv_ctrl_pkg::WB_LOAD;
          end
          rv_ctrl_pkg::OC_LOAD_W: begin
            // low half held until the upper beat
            mem_read_o   = 1'b1;
            addr_sel_o   = rv_ctrl_pkg::AS_LOAD;
            load_latch_o = 1'b1;
          end
          rv_ctrl_pkg::OC_STORE_BH, rv_ctrl_pkg::OC_STORE_W: begin
            mem_write_o = 1'b1;
            addr_sel_o  = rv_ctrl_pkg::AS_STORE;
          end
          // nop, fence, system
          default: ;
        endcase
      end
      rv_ctrl_pkg::ST_MEM_HI: begin
        upper_half_o = 1'b1;
        if (op_class_i == rv_ctrl_pkg::OC_LOAD_W) begin
          mem_read_o  = 1'b1;
          addr_sel_o  = rv_ctrl_pkg::AS_LOAD;
          reg_write_o = 1'b1;
          wb_sel_o    = rv_ctrl_pkg::WB_LOAD;
        end else begin
          mem_write_o = 1'b1;
          addr_sel_o  = rv_ctrl_pkg::AS_STORE;
        end
      end
      // start, all quiet
      default: ;
    endcase
  end

endmodule

//--- rv_instr_reg.sv
`timescale 1ns/1ps
`include "rv_ctrl_params.svh"

module rv_instr_reg (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  logic                   instr_lo_we_i,
  input  logic                   instr_hi_we_i,
  input  rv_isa_pkg::half_t      mem_rdata_i,
  output rv_ctrl_pkg::op_class_t op_class_o,
  output rv_isa_pkg::reg_addr_t  rs1_addr_o,
  output rv_isa_pkg::reg_addr_t  rs2_addr_o,
  output rv_isa_pkg::reg_addr_t  rd_addr_o,
  output rv_isa_pkg::funct3_t    funct3_o,
  output rv_isa_pkg::funct7_t    funct7_o,
  output rv_isa_pkg::word_t      i_imm_o,
  output rv_isa_pkg::word_t      s_imm_o,
  output rv_isa_pkg::word_t      b_imm_o,
  output rv_isa_pkg::word_t      j_imm_o,
  output rv_isa_pkg::word_t      u_imm_o
);

  rv_isa_pkg::instr_t instr_q;

  // class from the low half alone, size in funct3[1:0]
  function automatic rv_ctrl_pkg::op_class_t decode_class(input rv_isa_pkg::half_t lo);
    logic [4:0]             opcode;
    logic                   word_size;
    rv_ctrl_pkg::op_class_t oc;
    opcode    = lo[6:2];
    word_size = (lo[13:12] == 2'b10);
    case (opcode)
      `RV_OP_REG:    oc = rv_ctrl_pkg::OC_ALU_REG;
      `RV_OP_IMM:    oc = rv_ctrl_pkg::OC_ALU_IMM;
      `RV_OP_LUI:    oc = rv_ctrl_pkg::OC_LUI;
      `RV_OP_AUIPC:  oc = rv_ctrl_pkg::OC_AUIPC;
      `RV_OP_JAL:    oc = rv_ctrl_pkg::OC_JAL;
      `RV_OP_JALR:   oc = rv_ctrl_pkg::OC_JALR;
      `RV_OP_BRANCH: oc = rv_ctrl_pkg::OC_BRANCH;
      `RV_OP_LOAD:   oc = word_size ? rv_ctrl_pkg::OC_LOAD_W : rv_ctrl_pkg::OC_LOAD_BH;
      `RV_OP_STORE:  oc = word_size ? rv_ctrl_pkg::OC_STORE_W : rv_ctrl_pkg::OC_STORE_BH;
      // fence, system, unknown
      default:       oc = rv_ctrl_pkg::OC_NOP;
    endcase
    return oc;
  endfunction

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      op_class_o <= rv_ctrl_pkg::OC_NOP;
    end else if (instr_lo_we_i) begin
      op_class_o <= decode_class(mem_rdata_i);
    end
  end

  // instruction halves, one per fetch beat
  always_ff @(posedge clk_i) begin
    if (instr_lo_we_i) begin
      instr_q[15:0] <= mem_rdata_i;
    end
    if (instr_hi_we_i) begin
      instr_q[31:16] <= mem_rdata_i;
    end
  end

  assign rd_addr_o  = instr_q[11:7];
  assign rs1_addr_o = instr_q[19:15];
  assign rs2_addr_o = instr_q[24:20];
  assign funct3_o   = instr_q[14:12];
  assign funct7_o   = instr_q[31:25];

  // all immediates sign-extended from bit 31
  assign i_imm_o = {{(`RV_XLEN-12){instr_q[31]}}, instr_q[31:20]};
  assign s_imm_o = {{(`RV_XLEN-12){instr_q[31]}}, instr_q[31:25], instr_q[11:7]};
  assign b_imm_o = {{(`RV_XLEN-13){instr_q[31]}}, instr_q[31], instr_q[7],
                    instr_q[30:25], instr_q[11:8], 1'b0};
  assign j_imm_o = {{(`RV_XLEN-21){instr_q[31]}}, instr_q[31], instr_q[19:12],
                    instr_q[20], instr_q[30:21], 1'b0};
  assign u_imm_o = {instr_q[31:12], 12'b0};

endmodule

//--- rv_mem_port.sv
`timescale 1ns/1ps
`include "rv_ctrl_params.svh"

module rv_mem_port (
  input  logic                   clk_i,
  input  logic                   reset_i,
  input  rv_ctrl_pkg::addr_sel_t addr_sel_i,
  input  logic                   upper_half_i,
  input  logic                   load_latch_i,
  input  rv_isa_pkg::funct3_t    funct3_i,
  input  rv_isa_pkg::word_t      i_imm_i,
  input  rv_isa_pkg::word_t      s_imm_i,
  input  rv_isa_pkg::word_t      rs1_i,
  input  rv_isa_pkg::word_t      rs2_i,
  input  rv_isa_pkg::word_t      pc_i,
  input  rv_isa_pkg::half_t      mem_rdata_i,
  output rv_isa_pkg::word_t      mem_addr_o,
  output rv_isa_pkg::half_t      mem_wdata_o,
  output rv_isa_pkg::half_t      mem_wmask_o,
  output rv_isa_pkg::word_t      load_data_o
);

  rv_isa_pkg::word_t base_addr;
  rv_isa_pkg::half_t load_lo_q;
  logic              byte_size;
  logic [7:0]        load_byte;

  // funct3[1:0] gives access size
  assign byte_size = (funct3_i[1:0] == 2'b00);

  always_comb begin
    case (addr_sel_i)
      rv_ctrl_pkg::AS_LOAD:  base_addr = rs1_i + i_imm_i;
      rv_ctrl_pkg::AS_STORE: base_addr = rs1_i + s_imm_i;
      default:               base_addr = pc_i;
    endcase
  end

  // second beat of a word sits one halfword up
  assign mem_addr_o = upper_half_i ?
                      base_addr + rv_isa_pkg::word_t'(`RV_INSTR_STEP) : base_addr;

  // store data lanes
  always_comb begin
    if (upper_half_i) begin
      mem_wdata_o = rs2_i[31:16];
    end else if (byte_size) begin
      mem_wdata_o = mem_addr_o[0] ? {rs2_i[7:0], 8'h00} : {8'h00, rs2_i[7:0]};
    end else begin
      mem_wdata_o = rs2_i[15:0];
    end
  end

  // set bits protect the untouched byte
  always_comb begin
    mem_wmask_o = '0;
    if (addr_sel_i == rv_ctrl_pkg::AS_STORE && byte_size) begin
      mem_wmask_o = mem_addr_o[0] ? 16'h00FF : 16'hFF00;
    end
  end

  // lw low half, held for the upper beat
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      load_lo_q <= '0;
    end else if (load_latch_i) begin
      load_lo_q <= mem_rdata_i;
    end
  end

  assign load_byte = mem_addr_o[0] ? mem_rdata_i[15:8] : mem_rdata_i[7:0];

  // funct3[2] set means zero-extend
  always_comb begin
    case (funct3_i[1:0])
      2'b00: begin
        load_data_o = {{(`RV_XLEN-8){load_byte[7] & ~funct3_i[2]}}, load_byte};
      end
      2'b01: begin
        load_data_o = {{(`RV_XLEN-16){mem_rdata_i[15] & ~funct3_i[2]}}, mem_rdata_i};
      end
      default: load_data_o = {mem_rdata_i, load_lo_q};
    endcase
  end

endmodule

//--- rv_next_pc.sv
`timescale 1ns/1ps
`include "rv_ctrl_params.svh"

module rv_next_pc (
  input  rv_ctrl_pkg::pc_sel_t pc_sel_i,
  input  logic                 pc_write_req_i,
  input  logic                 branch_en_i,
  input  rv_isa_pkg::funct3_t  funct3_i,
  input  rv_isa_pkg::word_t    pc_i,
  input  rv_isa_pkg::word_t    rs1_i,
  input  rv_isa_pkg::word_t    i_imm_i,
  input  rv_isa_pkg::word_t    b_imm_i,
  input  rv_isa_pkg::word_t    j_imm_i,
  input  logic                 alu_equal_i,
  input  logic                 alu_less_i,
  input  logic                 alu_less_signed_i,
  output rv_isa_pkg::word_t    pc_o,
  output logic                 pc_write_o
);

  rv_isa_pkg::word_t instr_addr;
  rv_isa_pkg::word_t jalr_sum;
  logic              taken;

  // pc already two halfwords past the instruction in exec
  assign instr_addr = pc_i - rv_isa_pkg::word_t'(2 * `RV_INSTR_STEP);
  assign jalr_sum   = rs1_i + i_imm_i;

  always_comb begin
    case (pc_sel_i)
      rv_ctrl_pkg::PS_JAL:    pc_o = instr_addr + j_imm_i;
      rv_ctrl_pkg::PS_JALR:   pc_o = {jalr_sum[`RV_XLEN-1:1], 1'b0};
      rv_ctrl_pkg::PS_BRANCH: pc_o = instr_addr + b_imm_i;
      default:                pc_o = pc_i + rv_isa_pkg::word_t'(`RV_INSTR_STEP);
    endcase
  end

  // branch condition from alu flags
  always_comb begin
    case (funct3_i)
      `RV_F3_BEQ:  taken = alu_equal_i;
      `RV_F3_BNE:  taken = ~alu_equal_i;
      `RV_F3_BLT:  taken = alu_less_signed_i;
      `RV_F3_BGE:  taken = ~alu_less_signed_i;
      `RV_F3_BLTU: taken = alu_less_i;
      `RV_F3_BGEU: taken = ~alu_less_i;
      default:     taken = 1'b0;
    endcase
  end

  assign pc_write_o = pc_write_req_i | (branch_en_i & taken);

endmodule

//--- rv_writeback.sv
`timescale 1ns/1ps
`include "rv_ctrl_params.svh"

module rv_writeback (
  input  rv_ctrl_pkg::wb_sel_t wb_sel_i,
  input  logic                 alu_imm_i,
  input  rv_isa_pkg::word_t    u_imm_i,
  input  rv_isa_pkg::word_t    i_imm_i,
  input  rv_isa_pkg::word_t    pc_i,
  input  rv_isa_pkg::word_t    rs2_i,
  input  rv_isa_pkg::word_t    alu_out_i,
  input  rv_isa_pkg::word_t    load_data_i,
  output rv_isa_pkg::word_t    reg_wdata_o,
  output rv_isa_pkg::word_t    alu_operand2_o
);

  rv_isa_pkg::word_t instr_addr;

  // auipc base is the instruction address
  assign instr_addr = pc_i - rv_isa_pkg::word_t'(2 * `RV_INSTR_STEP);

  always_comb begin
    case (wb_sel_i)
      rv_ctrl_pkg::WB_UPPER:    reg_wdata_o = u_imm_i;
      rv_ctrl_pkg::WB_UPPER_PC: reg_wdata_o = u_imm_i + instr_addr;
      rv_ctrl_pkg::WB_LOAD:     reg_wdata_o = load_data_i;
      // return address, pc already stepped past the instruction
      rv_ctrl_pkg::WB_LINK:     reg_wdata_o = pc_i;
      default:                  reg_wdata_o = alu_out_i;
    endcase
  end

  // op-imm uses the sign-extended i-immediate
  assign alu_operand2_o = alu_imm_i ? i_imm_i : rs2_i;

endmodule

//--- rv_ctrl_top.sv
`timescale 1ns/1ps

module rv_ctrl_top (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  rv_isa_pkg::word_t     pc_i,
  output rv_isa_pkg::word_t     pc_o,
  output logic                  pc_write_o,
  output rv_isa_pkg::word_t     mem_addr_o,
  output logic                  mem_read_o,
  output logic                  mem_write_o,
  output rv_isa_pkg::half_t     mem_wdata_o,
  output rv_isa_pkg::half_t     mem_wmask_o,
  input  rv_isa_pkg::half_t     mem_rdata_i,
  output rv_isa_pkg::reg_addr_t rs1_addr_o,
  output rv_isa_pkg::reg_addr_t rs2_addr_o,
  output rv_isa_pkg::reg_addr_t rd_addr_o,
  output rv_isa_pkg::funct3_t   funct3_o,
  output rv_isa_pkg::funct7_t   funct7_o,
  input  rv_isa_pkg::word_t     rs1_i,
  input  rv_isa_pkg::word_t     rs2_i,
  input  rv_isa_pkg::word_t     alu_out_i,
  output rv_isa_pkg::word_t     alu_operand2_o,
  output logic                  alu_imm_o,
  input  logic                  alu_equal_i,
  input  logic                  alu_less_i,
  input  logic                  alu_less_signed_i,
  output logic                  reg_write_o,
  output rv_isa_pkg::word_t     reg_wdata_o
);

  // sequencer controls
  rv_ctrl_pkg::op_class_t op_class;
  rv_ctrl_pkg::addr_sel_t addr_sel;
  rv_ctrl_pkg::wb_sel_t   wb_sel;
  rv_ctrl_pkg::pc_sel_t   pc_sel;
  logic                   instr_lo_we;
  logic                   instr_hi_we;
  logic                   upper_half;
  logic                   load_latch;
  logic                   pc_write_req;
  logic                   branch_en;
  // decoded immediates
  rv_isa_pkg::word_t      i_imm;
  rv_isa_pkg::word_t      s_imm;
  rv_isa_pkg::word_t      b_imm;
  rv_isa_pkg::word_t      j_imm;
  rv_isa_pkg::word_t      u_imm;
  rv_isa_pkg::word_t      load_data;

  rv_sequencer u_sequencer (
    .clk_i          (clk_i),
    .reset_i        (reset_i),
    .op_class_i     (op_class),
    .mem_read_o     (mem_read_o),
    .mem_write_o    (mem_write_o),
    .instr_lo_we_o  (instr_lo_we),
    .instr_hi_we_o  (instr_hi_we),
    .addr_sel_o     (addr_sel),
    .upper_half_o   (upper_half),
    .load_latch_o   (load_latch),
    .reg_write_o    (reg_write_o),
    .wb_sel_o       (wb_sel),
    .pc_sel_o       (pc_sel),
    .pc_write_req_o (pc_write_req),
    .branch_en_o    (branch_en),
    .alu_imm_o      (alu_imm_o)
  );

  rv_instr_reg u_instr_reg (
    .clk_i         (clk_i),
    .reset_i       (reset_i),
    .instr_lo_we_i (instr_lo_we),
    .instr_hi_we_i (instr_hi_we),
    .mem_rdata_i   (mem_rdata_i),
    .op_class_o    (op_class),
    .rs1_addr_o    (rs1_addr_o),
    .rs2_addr_o    (rs2_addr_o),
    .rd_addr_o     (rd_addr_o),
    .funct3_o      (funct3_o),
    .funct7_o      (funct7_o),
    .i_imm_o       (i_imm),
    .s_imm_o       (s_imm),
    .b_imm_o       (b_imm),
    .j_imm_o       (j_imm),
    .u_imm_o       (u_imm)
  );

  rv_mem_port u_mem_port (
    .clk_i        (clk_i),
    .reset_i      (reset_i),
    .addr_sel_i   (addr_sel),
    .upper_half_i (upper_half),
    .load_latch_i (load_latch),
    .funct3_i     (funct3_o),
    .i_imm_i      (i_imm),
    .s_imm_i      (s_imm),
    .rs1_i        (rs1_i),
    .rs2_i        (rs2_i),
    .pc_i         (pc_i),
    .mem_rdata_i  (mem_rdata_i),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_wmask_o  (mem_wmask_o),
    .load_data_o  (load_data)
  );

  rv_next_pc u_next_pc (
    .pc_sel_i          (pc_sel),
    .pc_write_req_i    (pc_write_req),
    .branch_en_i       (branch_en),
    .funct3_i          (funct3_o),
    .pc_i              (pc_i),
    .rs1_i             (rs1_i),
    .i_imm_i           (i_imm),
    .b_imm_i           (b_imm),
    .j_imm_i           (j_imm),
    .alu_equal_i       (alu_equal_i),
    .alu_less_i        (alu_less_i),
    .alu_less_signed_i (alu_less_signed_i),
    .pc_o              (pc_o),
    .pc_write_o        (pc_write_o)
  );

  rv_writeback u_writeback (
    .wb_sel_i       (wb_sel),
    .alu_imm_i      (alu_imm_o),
    .u_imm_i        (u_imm),
    .i_imm_i        (i_imm),
    .pc_i           (pc_i),
    .rs2_i          (rs2_i),
    .alu_out_i      (alu_out_i),
    .load_data_i    (load_data),
    .reg_wdata_o    (reg_wdata_o),
    .alu_operand2_o (alu_operand2_o)
  );

endmodule

//--- rv_ctrl_chk.sv
`timescale 1ns/1ps

module rv_ctrl_chk (
  input logic        clk_i,
  input logic        reset_i,
  input logic        mem_read_o,
  input logic        mem_write_o,
  input logic [15:0] mem_wmask_o,
  input logic        reg_write_o,
  input logic        pc_write_o
);

  // one memory access per cycle
  a_rw_exclusive: assert property (@(posedge clk_i) !(mem_read_o && mem_write_o))
    else $error("memory read and write strobes high together");

  // mask only with a write
  a_mask_write: assert property (@(posedge clk_i) (mem_wmask_o != '0) |-> mem_write_o)
    else $error("write mask set without a write");

  a_reset_quiet: assert property (@(posedge clk_i)
    reset_i |=> !(mem_read_o || mem_write_o || reg_write_o || pc_write_o))
    else $error("strobe active right after reset");

  // a single register write per instruction
  a_reg_write_pulse: assert property (@(posedge clk_i) disable iff (reset_i)
    reg_write_o |=> !reg_write_o)
    else $error("register write high in two cycles in a row");

endmodule

//--- rv_ctrl_tb.sv
`timescale 1ns/1ps

module rv_ctrl_tb;

  // 28 instructions of at most 4 cycles each plus reset and slack
  localparam int max_cycles = 4 * 28 + 50;

  logic clk_i = 1'b0;
  logic reset_i = 1'b1;
  logic [31:0] pc_i = '0, rs1_i = '0, rs2_i = '0, alu_out_i = '0;
  logic [15:0] mem_rdata_i = '0;
  logic alu_equal_i = 1'b0, alu_less_i = 1'b0, alu_less_signed_i = 1'b0;
  logic [31:0] pc_o, mem_addr_o, alu_operand2_o, reg_wdata_o;
  logic [15:0] mem_wdata_o, mem_wmask_o;
  logic [4:0] rs1_addr_o, rs2_addr_o, rd_addr_o;
  logic [2:0] funct3_o;
  logic [6:0] funct7_o;
  logic pc_write_o, mem_read_o, mem_write_o, alu_imm_o, reg_write_o;

  // models of the parts outside the controller
  logic [15:0] mem [0:511];
  logic [31:0] rf [0:31];
  logic [31:0] pc_q = '0;
  int cycle_cnt = 0, rw_cnt = 0, mw_cnt = 0;
  logic [4:0] rw_rd;
  logic [31:0] rw_data, mw_addr [0:1];
  logic [15:0] mw_data [0:1], mw_mask [0:1];
  // exec-cycle snapshot
  logic [31:0] sn_op2, sn_addr0, sn_addr1, start_pc;
  logic [4:0] sn_rs1, sn_rs2;
  logic [2:0] sn_f3;
  logic [6:0] sn_f7;
  logic sn_imm, sn_read;
  int cycles, rw0, mw0;

  rv_ctrl_top u_rv_ctrl_top (.*);

  bind rv_ctrl_top rv_ctrl_chk u_chk (.*);

  always #10 clk_i = ~clk_i;

  // pc, register reads, alu and memory read settle in that order
  always @(negedge clk_i) begin
    pc_i = pc_q;
    #1;
    rs1_i = rf[rs1_addr_o];
    rs2_i = rf[rs2_addr_o];
    #1;
    alu_out_i = rs1_i + alu_operand2_o;
    alu_equal_i = (rs1_i == rs2_i);
    alu_less_i = (rs1_i < rs2_i);
    alu_less_signed_i = ($signed(rs1_i) < $signed(rs2_i));
    mem_rdata_i = mem[mem_addr_o[9:1]];
  end

  // register file, memory and pc register updates
  always @(posedge clk_i) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_cnt > max_cycles) begin
      $display("timeout: the DUT did not finish the tests in %0d cycles", max_cycles);
      $display("SOME TESTS FAILED");
      $fatal(1, "run stopped by the cycle limit");
    end else if (!reset_i) begin
      if (reg_write_o) begin
        if (rd_addr_o != 5'd0) rf[rd_addr_o] = reg_wdata_o;
        rw_cnt = rw_cnt + 1;
        rw_rd = rd_addr_o;
        rw_data = reg_wdata_o;
      end
      if (mem_write_o) begin
        // set mask bits keep the old data
        mem[mem_addr_o[9:1]] = (mem[mem_addr_o[9:1]] & mem_wmask_o) |
                               (mem_wdata_o & ~mem_wmask_o);
        mw_addr[mw_cnt % 2] = mem_addr_o;
        mw_data[mw_cnt % 2] = mem_wdata_o;
        mw_mask[mw_cnt % 2] = mem_wmask_o;
        mw_cnt = mw_cnt + 1;
      end
      if (pc_write_o) pc_q = pc_o;
    end
  end

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (exp !== act) begin
      $display("ERROR %s: expected %h, actual %h", name, exp, act);
      $display("SOME TESTS FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  function automatic logic [31:0] enc_i(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
                                        logic [4:0] rd, logic [6:0] op);
    return {imm, rs1, f3, rd, op};
  endfunction

  function automatic logic [31:0] enc_s(logic [11:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[11:5], rs2, rs1, f3, imm[4:0], 7'h23};
  endfunction

  function automatic logic [31:0] enc_b(logic [12:0] imm, logic [4:0] rs2, logic [4:0] rs1,
                                        logic [2:0] f3);
    return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], 7'h63};
  endfunction

  // taken condition straight from the isa
  function automatic logic branch_rule(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
    case (f3)
      3'b000: return a == b;
      3'b001: return a != b;
      3'b100: return $signed(a) < $signed(b);
      3'b101: return $signed(a) >= $signed(b);
      3'b110: return a < b;
      default: return a >= b;
    endcase
  endfunction

  // places one instruction at pc, runs it to the next fetch
  task automatic run_instr(input string name, input logic [31:0] instr);
    start_pc = pc_q;
    mem[start_pc[9:1]] = instr[15:0];
    mem[start_pc[9:1] + 9'd1] = instr[31:16];
    rw0 = rw_cnt;
    mw0 = mw_cnt;
    for (int h = 0; h < 2; h++) begin
      @(negedge clk_i);
      #3;
      check({name, " fetch read"}, 1, mem_read_o);
      check({name, " fetch addr"}, start_pc + 2 * h, mem_addr_o);
      check({name, " fetch pc write"}, 1, pc_write_o);
      check({name, " fetch pc"}, start_pc + 2 * h + 2, pc_o);
      @(posedge clk_i);
    end
    @(negedge clk_i);
    #3;
    sn_rs1 = rs1_addr_o;
    sn_rs2 = rs2_addr_o;
    sn_f3 = funct3_o;
    sn_f7 = funct7_o;
    sn_op2 = alu_operand2_o;
    sn_imm = alu_imm_o;
    sn_addr0 = mem_addr_o;
    sn_read = mem_read_o;
    cycles = 3;
    @(posedge clk_i);
    #1;
    while (u_rv_ctrl_top.u_sequencer.state_q != rv_ctrl_pkg::ST_FETCH_LO) begin
      @(negedge clk_i);
      #3;
      sn_addr1 = mem_addr_o;
      cycles = cycles + 1;
      @(posedge clk_i);
      #1;
    end
  endtask

  task automatic check_seq(input string name, input int cyc, input logic [31:0] pc_exp,
                           input int writes);
    check({name, " cycles"}, cyc, cycles);
    check({name, " next pc"}, pc_exp, pc_q);
    check({name, " reg writes"}, writes, rw_cnt - rw0);
  endtask

  task automatic test_reset_fetch();
    logic [31:0] exp;
    exp = rf[1] + rf[2];
    run_instr("add", {7'h00, 5'd2, 5'd1, 3'b000, 5'd3, 7'h33});
    check_seq("add", 3, start_pc + 4, 1);
    check("add rs1", 1, sn_rs1);
    check("add rs2", 2, sn_rs2);
    check("add rd", 3, rw_rd);
    check("add imm sel", 0, sn_imm);
    check("add operand2", rf[2], sn_op2);
    check("add result", exp, rw_data);
    exp = rf[5] + rf[6];
    run_instr("sub", {7'h20, 5'd6, 5'd5, 3'b000, 5'd4, 7'h33});
    check_seq("sub", 3, start_pc + 4, 1);
    check("sub funct7", 7'h20, sn_f7);
    check("sub funct3", 0, sn_f3);
    check("sub result", exp, rw_data);
  endtask

  task automatic test_immediates();
    logic [31:0] exp;
    exp = rf[1] - 32'd5;
    run_instr("addi neg", enc_i(12'hFFB, 5'd1, 3'b000, 5'd7, 7'h13));
    check_seq("addi neg", 3, start_pc + 4, 1);
    check("addi neg imm sel", 1, sn_imm);
    check("addi neg operand2", 32'hFFFF_FFFB, sn_op2);
    check("addi neg result", exp, rw_data);
    run_instr("addi pos", enc_i(12'h7FF, 5'd1, 3'b000, 5'd8, 7'h13));
    check("addi pos operand2", 32'h0000_07FF, sn_op2);
    run_instr("lui", {20'hABCDE, 5'd9, 7'h37});
    check_seq("lui", 3, start_pc + 4, 1);
    check("lui result", 32'hABCD_E000, rw_data);
    run_instr("auipc", {20'h12345, 5'd10, 7'h17});
    check("auipc result", start_pc + 32'h1234_5000, rw_data);
  endtask

  task automatic load_case(input string name, input logic [2:0] f3, input logic [11:0] off,
                           input logic [31:0] exp);
    run_instr(name, enc_i(off, 5'd11, f3, 5'd12, 7'h03));
    check_seq(name, (f3 == 3'b010) ? 4 : 3, start_pc + 4, 1);
    check({name, " read"}, 1, sn_read);
    check({name, " addr"}, 32'h100 + off, sn_addr0);
    if (f3 == 3'b010) check({name, " upper addr"}, 32'h102 + off, sn_addr1);
    check({name, " result"}, exp, rw_data);
  endtask

  task automatic test_loads();
    rf[11] = 32'h100;
    mem[9'h080] = 16'h80F1;
    mem[9'h081] = 16'h7A85;
    load_case("lb even", 3'b000, 12'd0, 32'hFFFF_FFF1);
    load_case("lb odd", 3'b000, 12'd1, 32'hFFFF_FF80);
    load_case("lbu even", 3'b100, 12'd0, 32'h0000_00F1);
    load_case("lbu odd", 3'b100, 12'd1, 32'h0000_0080);
    load_case("lh neg", 3'b001, 12'd0, 32'hFFFF_80F1);
    load_case("lhu", 3'b101, 12'd0, 32'h0000_80F1);
    load_case("lh pos", 3'b001, 12'd2, 32'h0000_7A85);
    load_case("lw", 3'b010, 12'd0, 32'h7A85_80F1);
  endtask

  task automatic store_case(input string name, input logic [2:0] f3, input logic [11:0] off,
                            input logic [15:0] data, input logic [15:0] mask,
                            input logic [15:0] mem_exp);
    logic [31:0] addr;
    addr = 32'h120 + off;
    run_instr(name, enc_s(off, 5'd15, 5'd14, f3));
    check_seq(name, (f3 == 3'b010) ? 4 : 3, start_pc + 4, 0);
    check({name, " write addr"}, addr, mw_addr[mw0 % 2]);
    check({name, " write data"}, data, mw_data[mw0 % 2]);
    check({name, " write mask"}, mask, mw_mask[mw0 % 2]);
    check({name, " memory"}, mem_exp, mem[addr[9:1]]);
  endtask

  task automatic test_stores();
    rf[14] = 32'h120;
    rf[15] = 32'hCAFE_1234;
    for (int i = 9'h090; i < 9'h096; i++) mem[i] = 16'hFFFF;
    store_case("sb even", 3'b000, 12'd0, 16'h0034, 16'hFF00, 16'hFF34);
    store_case("sb odd", 3'b000, 12'd3, 16'h3400, 16'h00FF, 16'h34FF);
    store_case("sh", 3'b001, 12'd4, 16'h1234, 16'h0000, 16'h1234);
    store_case("sw", 3'b010, 12'd8, 16'h1234, 16'h0000, 16'h1234);
    check("sw writes", 2, mw_cnt - mw0);
    check("sw upper addr", 32'h12A, mw_addr[(mw0 + 1) % 2]);
    check("sw upper data", 16'hCAFE, mw_data[(mw0 + 1) % 2]);
    check("sw upper mask", 0, mw_mask[(mw0 + 1) % 2]);
    check("sw upper memory", 16'hCAFE, mem[9'h095]);
  endtask

  task automatic test_control();
    logic [2:0] f3s [0:5];
    f3s = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
    run_instr("jal", {1'b0, 10'd8, 1'b0, 8'd0, 5'd16, 7'h6F});
    check_seq("jal", 3, start_pc + 16, 1);
    check("jal link", start_pc + 4, rw_data);
    rf[18] = 32'h40;
    run_instr("jalr", enc_i(12'd5, 5'd18, 3'b000, 5'd17, 7'h67));
    check_seq("jalr", 3, 32'h44, 1);
    check("jalr link", start_pc + 4, rw_data);
    rf[19] = 32'hFFFF_FFFF;
    rf[20] = 32'h1;
    for (int b = 0; b < 6; b++) begin
      run_instr("branch", enc_b(13'd8, 5'd20, 5'd19, f3s[b]));
      check_seq("branch", 3, branch_rule(f3s[b], rf[19], rf[20]) ? start_pc + 8 :
                start_pc + 4, 0);
    end
  endtask

  task automatic test_nops();
    logic [31:0] keep;
    keep = rf[21];
    run_instr("fence", 32'h0000_000F);
    check_seq("fence", 3, start_pc + 4, 0);
    check("fence stores", 0, mw_cnt - mw0);
    run_instr("unknown", enc_i(12'h123, 5'd1, 3'b000, 5'd21, 7'h2B));
    check_seq("unknown", 3, start_pc + 4, 0);
    check("unknown stores", 0, mw_cnt - mw0);
    check("unknown rd kept", keep, rf[21]);
  endtask

  initial begin
    void'($urandom(80398));
    // background pattern tied to the halfword address
    for (int i = 0; i < 512; i++) mem[i] = 16'hA500 ^ 16'(i);
    rf[0] = '0;
    for (int i = 1; i < 32; i++) rf[i] = $urandom;
    repeat (5) @(negedge clk_i);
    reset_i = 1'b0;
    // all strobes quiet in the start cycle
    #3;
    check("start strobes", 0, {mem_read_o, mem_write_o, reg_write_o, pc_write_o});
    @(posedge clk_i);
    #1;
    test_reset_fetch();
    test_immediates();
    test_loads();
    test_stores();
    test_control();
    test_nops();
    $display("ALL TESTS PASSED");
    $finish;
  end

endmodule

//--- src.f
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_sequencer.sv
rv_instr_reg.sv
rv_mem_port.sv
rv_next_pc.sv
rv_writeback.sv
rv_ctrl_top.sv
rv_ctrl_chk.sv
rv_ctrl_tb.sv

//--- run.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -I. -f src.f --top-module rv_ctrl_tb -o rv_ctrl_sim
./obj_dir/rv_ctrl_sim
